// File: source/glue_pkg.sv
// shared bus structs, device select codes and memory-map constants; imported by the glue RTL
package glue_pkg;

  typedef struct packed {
    logic dragon;            // dragon map instead of coco
    logic dragon64;          // pia0/acia split, two rom banks
    logic disk_cart_enabled; // disk rom sits in the romc slot
  } machine_cfg_t;

  typedef struct packed {
    logic [15:0] addr;
    logic        rw;         // 1 = read
    logic        clk_e;
    logic        clk_q;
  } cpu_bus_t;

  typedef struct packed {
    logic [2:0] dev_sel;     // sam s0..s2
    logic [7:0] ma;          // muxed ram address
    logic       ras_n;
    logic       cas_n;
    logic       wr_ena;      // write strobe paced by the sam
  } sam_bus_t;

  typedef struct packed {
    logic ram;
    logic rom8;
    logic rom8_alt;
    logic roma;
    logic roma_alt;
    logic romc;
    logic pia0;
    logic pia1;
    logic acia;
    logic io;
  } dev_sel_t;

  typedef struct packed {
    logic ff40_wr;
    logic ff40_rd;
    logic wd_data_rd;
    logic wd_rd;
    logic wd_wr;
  } disk_strobe_t;

  typedef struct packed {
    logic [7:0] rom8;
    logic [7:0] rom8_alt;
    logic [7:0] roma;
    logic [7:0] roma_alt;
    logic [7:0] romc_disk;
    logic [7:0] pia0;
    logic [7:0] pia1;
    logic [7:0] acia;
    logic [7:0] io;
  } src_data_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  data;
    logic [5:0]  index;
    logic        download;   // high during a transfer
    logic        wr;
  } ioctl_t;

  typedef struct packed {
    logic [7:0] x;
    logic [7:0] y;
  } joy_pos_t;

  // sam device select codes, 74ls138 outputs
  localparam logic [2:0] sel_ram  = 3'd0;
  localparam logic [2:0] sel_rom8 = 3'd1;
  localparam logic [2:0] sel_roma = 3'd2;
  localparam logic [2:0] sel_romc = 3'd3;
  localparam logic [2:0] sel_pia0 = 3'd4;
  localparam logic [2:0] sel_pia1 = 3'd5;
  localparam logic [2:0] sel_io   = 3'd6;

  localparam logic [5:0]  cart_index   = 6'd1;
  localparam logic [15:0] cart_min_len = 16'h0100; // shorter transfer means no image

  localparam logic [7:0] joy_center = 8'd128;
  localparam logic [7:0] joy_max    = 8'd255;
  localparam logic [7:0] joy_min    = 8'd0;

endpackage

// File: source/sys_control.sv
// reset stretcher and cassette 1.78 mhz tick; sys_ready gates the cpu, cas_tick feeds the writer
module sys_control #(
  parameter int RESET_HOLD = 256,
  parameter int TICK_DIV   = 32
) (
  input  logic clk,
  input  logic l_reset,
  output logic sys_ready,
  output logic cas_tick
);

  localparam int HOLD_W = $clog2(RESET_HOLD + 1);
  localparam int TICK_W = $clog2(TICK_DIV);

  logic [HOLD_W-1:0] hold_cnt; // cycles left before release
  logic [TICK_W-1:0] tick_cnt; // free running, wraps at TICK_DIV

  always_ff @(posedge clk or posedge l_reset)
  begin
    if (l_reset)
    begin
      hold_cnt  <= HOLD_W'(RESET_HOLD);
      sys_ready <= 1'b0;
      tick_cnt  <= '0;
      cas_tick  <= 1'b0;
    end
    else
    begin
      if (hold_cnt != '0)
        hold_cnt <= hold_cnt - 1'b1;
      sys_ready <= (hold_cnt <= HOLD_W'(1)); // high once the last hold cycle is done
      tick_cnt  <= tick_cnt + 1'b1;
      cas_tick  <= (tick_cnt == TICK_W'(27)); // phase the cassette writer expects
    end
  end

endmodule

// File: source/device_decode.sv
// sam device select to chip selects and floppy strobes; purely combinational, used by the top level
module device_decode import glue_pkg::*; (
  input  machine_cfg_t cfg,
  input  cpu_bus_t     bus,
  input  sam_bus_t     sam,
  input  logic         ddrb2,  // pia1 ddrb bit 2
  input  logic         portb2, // pia1 port b bit 2
  output dev_sel_t     sel,
  output disk_strobe_t disk
);

  logic rom8_cs;
  logic roma_cs;
  logic pia_orig_cs; // pia0 slot before the d64 split
  logic alt_bank;    // d64 second rom bank
  logic acia_hit;
  logic a3;          // register select bit, flipped on a dragon
  logic wd_addr;     // wd1793 window

  // 3-to-8 decode of the sam select
  always_comb
  begin
    sel         = '0;
    rom8_cs     = 1'b0;
    roma_cs     = 1'b0;
    pia_orig_cs = 1'b0;
    case (sam.dev_sel)
      sel_ram:  sel.ram = 1'b1;
      sel_rom8: rom8_cs = 1'b1;
      sel_roma: roma_cs = 1'b1;
      sel_romc: sel.romc = 1'b1;
      sel_pia0: pia_orig_cs = 1'b1;
      sel_pia1: sel.pia1 = 1'b1;
      sel_io:   sel.io = 1'b1;
      default:  sel = '0; // code 7 selects nothing
    endcase

    // ddrb2 as output and driven low swaps in the alternate roms
    sel.rom8     = rom8_cs & ~alt_bank;
    sel.rom8_alt = rom8_cs & alt_bank;
    sel.roma     = roma_cs & ~alt_bank;
    sel.roma_alt = roma_cs & alt_bank;

    sel.pia0 = pia_orig_cs & ~acia_hit;
    sel.acia = pia_orig_cs & acia_hit;
  end

  assign alt_bank = cfg.dragon64 & ddrb2 & ~portb2;
  assign acia_hit = cfg.dragon64 & bus.addr[2]; // a2 high is the serial chip

  // floppy register map differs between coco and dragon
  assign a3      = bus.addr[3] ^ cfg.dragon;
  assign wd_addr = a3 & ~(cfg.dragon & bus.addr[2]);

  always_comb
  begin
    disk.ff40_rd    = sel.io & ~a3 & (bus.addr[2:0] == 3'b000); // drive control latch
    disk.ff40_wr    = disk.ff40_rd & ~bus.rw & sam.wr_ena;
    disk.wd_data_rd = sel.io & wd_addr;
    disk.wd_rd      = sel.io & wd_addr & bus.rw & (bus.clk_e | bus.clk_q);
    disk.wd_wr      = sel.io & wd_addr & ~bus.rw & sam.wr_ena;
  end

endmodule

// File: source/cart_store.sv
// cartridge rom image, filled over the download port and read in the romc slot by the cpu
module cart_store import glue_pkg::*; #(
  parameter int CART_AW = 14
) (
  input  logic               clk,
  input  logic               l_reset,
  input  ioctl_t             ioctl,
  input  logic [CART_AW-1:0] addr,              // cpu address
  input  logic               romc_sel,
  input  logic               disk_cart_enabled,
  output logic [7:0]         cart_dout,
  output logic               cart_loaded
);

  logic [7:0] mem [2**CART_AW];

  logic load_cart;   // transfer targets the cartridge
  logic download_d;  // previous download level
  logic load_done;   // end of a cartridge transfer
  logic rd_en;

  assign load_cart = (ioctl.index == cart_index);
  assign load_done = download_d & ~ioctl.download & load_cart;
  assign rd_en     = romc_sel & cart_loaded; // no image, no reads

  // download side write port
  always_ff @(posedge clk)
  begin
    if (ioctl.wr && load_cart)
      mem[ioctl.addr[CART_AW-1:0]] <= ioctl.data;
  end

  // cpu side read port, holds last byte when idle
  always_ff @(posedge clk)
  begin
    if (rd_en)
      cart_dout <= mem[addr];
  end

  always_ff @(posedge clk or posedge l_reset)
  begin
    if (l_reset)
    begin
      download_d  <= 1'b0;
      cart_loaded <= 1'b0;
    end
    else
    begin
      download_d <= ioctl.download;
      if (load_done)
        cart_loaded <= (ioctl.addr > cart_min_len); // last address tells the size
      else if (disk_cart_enabled)
        cart_loaded <= 1'b0; // disk rom takes the slot
    end
  end

endmodule

// File: source/read_path.sv
// cpu read capture on ras rise, read data mux, and video address and byte latches from the sam bus
module read_path import glue_pkg::*; (
  input  logic         clk,
  input  logic         l_reset,
  input  logic         spd_ena,    // sam pacing enable
  input  cpu_bus_t     bus,
  input  sam_bus_t     sam,
  input  dev_sel_t     sel,
  input  machine_cfg_t cfg,
  input  src_data_t    src,
  input  logic [7:0]   cart_dout,
  input  logic [7:0]   vid_data,   // ram read port
  output logic [7:0]   cpu_din,
  output logic [15:0]  video_addr,
  output logic [7:0]   vdg_byte
);

  // sources held from the ras rise
  typedef struct packed {
    logic [7:0] ram;
    logic [7:0] rom8;
    logic [7:0] rom8_alt;
    logic [7:0] roma;
    logic [7:0] roma_alt;
    logic [7:0] romc;
    logic [7:0] pia0;
    logic [7:0] pia1;
  } cap_t;

  cap_t       cap;
  logic       ras_r;
  logic       cas_r;
  logic       q_r;
  logic       ras_rise;
  logic       ras_fall;
  logic       cas_fall;
  logic       q_rise;
  logic [7:0] romc_src;

  assign ras_rise = spd_ena & sam.ras_n & ~ras_r & bus.clk_e; // end of cpu cycle
  assign ras_fall = spd_ena & ~sam.ras_n & ras_r;
  assign cas_fall = spd_ena & ~sam.cas_n & cas_r;
  assign q_rise   = spd_ena & bus.clk_q & ~q_r;

  assign romc_src = cfg.disk_cart_enabled ? src.romc_disk : cart_dout;

  always_ff @(posedge clk or posedge l_reset)
  begin
    if (l_reset)
    begin
      ras_r      <= 1'b0;
      cas_r      <= 1'b0;
      q_r        <= 1'b0;
      cap        <= '0;
      video_addr <= '0;
      vdg_byte   <= '0;
    end
    else if (spd_ena)
    begin
      if (ras_rise)
      begin
        cap.ram      <= vid_data;
        cap.rom8     <= src.rom8;
        cap.rom8_alt <= src.rom8_alt;
        cap.roma     <= src.roma;
        cap.roma_alt <= src.roma_alt;
        cap.romc     <= romc_src;
        cap.pia0     <= src.pia0;
        cap.pia1     <= src.pia1;
      end
      if (ras_fall)
        video_addr[7:0] <= sam.ma;  // row
      if (cas_fall)
        video_addr[15:8] <= sam.ma; // column
      if (q_rise)
      begin
        vdg_byte <= vid_data;
        cap.ram  <= vid_data;
      end
      ras_r <= sam.ras_n;
      cas_r <= sam.cas_n;
      q_r   <= bus.clk_q;
    end
  end

  // first active select wins
  always_comb
  begin
    if (sel.ram)
      cpu_din = cap.ram;
    else if (sel.rom8)
      cpu_din = cap.rom8;
    else if (sel.rom8_alt)
      cpu_din = cap.rom8_alt;
    else if (sel.roma)
      cpu_din = cap.roma;
    else if (sel.roma_alt)
      cpu_din = cap.roma_alt;
    else if (sel.romc)
      cpu_din = cap.romc;
    else if (sel.acia)
      cpu_din = src.acia; // live, stub device
    else if (sel.pia0)
      cpu_din = cap.pia0;
    else if (sel.pia1)
      cpu_din = cap.pia1;
    else if (sel.io)
      cpu_din = src.io;   // live, fdc drives it
    else
      cpu_din = 8'hff;    // open bus
  end

endmodule

// File: source/joystick_pos.sv
// registered joystick positions from the d-pad or the analog sticks, read by the joystick dac
module joystick_pos import glue_pkg::*; (
  input  logic       clk,
  input  logic       l_reset,
  input  logic       use_dpad,
  input  logic [3:0] dpad1,    // bit 0 right, 1 left, 2 down, 3 up
  input  logic [3:0] dpad2,
  input  joy_pos_t   analog1,
  input  joy_pos_t   analog2,
  output joy_pos_t   joy_pos1,
  output joy_pos_t   joy_pos2
);

  // later checks win, so left beats right and up beats down
  function automatic joy_pos_t dpad_pos(input logic [3:0] d);
    joy_pos_t p;
    p.x = joy_center;
    p.y = joy_center;
    if (d[0])
      p.x = joy_max;
    if (d[1])
      p.x = joy_min;
    if (d[2])
      p.y = joy_max;
    if (d[3])
      p.y = joy_min;
    return p;
  endfunction

  always_ff @(posedge clk or posedge l_reset)
  begin
    if (l_reset)
    begin
      joy_pos1 <= '{x: joy_center, y: joy_center};
      joy_pos2 <= '{x: joy_center, y: joy_center};
    end
    else if (use_dpad)
    begin
      joy_pos1 <= dpad_pos(dpad1);
      joy_pos2 <= dpad_pos(dpad2);
    end
    else
    begin
      joy_pos1 <= analog1; // passed through as is
      joy_pos2 <= analog2;
    end
  end

endmodule

// File: source/dragon_bus_glue.sv
// top of the dragon/coco bus glue, wiring reset, decode, cartridge, read path and joystick blocks
module dragon_bus_glue import glue_pkg::*; #(
  parameter int RESET_HOLD = 256, // cpu needs reset over two slow cycles
  parameter int TICK_DIV   = 32,
  parameter int CART_AW    = 14   // 16k cartridge
) (
  input  logic         clk,
  input  logic         l_reset,
  input  machine_cfg_t cfg,
  input  cpu_bus_t     bus,
  input  sam_bus_t     sam,
  input  logic         spd_ena,
  input  logic         ddrb2,
  input  logic         portb2,
  input  src_data_t    src,
  input  logic [7:0]   vid_data,
  input  ioctl_t       ioctl,
  input  logic         use_dpad,
  input  logic [3:0]   dpad1,
  input  logic [3:0]   dpad2,
  input  joy_pos_t     analog1,
  input  joy_pos_t     analog2,
  output logic         sys_ready,
  output logic         cas_tick,
  output dev_sel_t     sel,
  output disk_strobe_t disk,
  output logic [7:0]   cpu_din,
  output logic [15:0]  video_addr,
  output logic [7:0]   vdg_byte,
  output logic         cart_loaded,
  output joy_pos_t     joy_pos1,
  output joy_pos_t     joy_pos2
);

  logic [7:0] cart_dout; // cartridge byte into the romc capture

  sys_control #(
    .RESET_HOLD (RESET_HOLD),
    .TICK_DIV   (TICK_DIV)
  ) sys_control_i (
    .clk       (clk),
    .l_reset   (l_reset),
    .sys_ready (sys_ready),
    .cas_tick  (cas_tick)
  );

  device_decode device_decode_i (
    .cfg    (cfg),
    .bus    (bus),
    .sam    (sam),
    .ddrb2  (ddrb2),
    .portb2 (portb2),
    .sel    (sel),
    .disk   (disk)
  );

  cart_store #(
    .CART_AW (CART_AW)
  ) cart_store_i (
    .clk               (clk),
    .l_reset           (l_reset),
    .ioctl             (ioctl),
    .addr              (bus.addr[CART_AW-1:0]),
    .romc_sel          (sel.romc),
    .disk_cart_enabled (cfg.disk_cart_enabled),
    .cart_dout         (cart_dout),
    .cart_loaded       (cart_loaded)
  );

  read_path read_path_i (
    .clk        (clk),
    .l_reset    (l_reset),
    .spd_ena    (spd_ena),
    .bus        (bus),
    .sam        (sam),
    .sel        (sel),
    .cfg        (cfg),
    .src        (src),
    .cart_dout  (cart_dout),
    .vid_data   (vid_data),
    .cpu_din    (cpu_din),
    .video_addr (video_addr),
    .vdg_byte   (vdg_byte)
  );

  joystick_pos joystick_pos_i (
    .clk      (clk),
    .l_reset  (l_reset),
    .use_dpad (use_dpad),
    .dpad1    (dpad1),
    .dpad2    (dpad2),
    .analog1  (analog1),
    .analog2  (analog2),
    .joy_pos1 (joy_pos1),
    .joy_pos2 (joy_pos2)
  );

endmodule

// File: tb/tb_dragon_bus_glue.sv
// random self-checking testbench for the bus glue top; a cycle model in here predicts every output
module tb_dragon_bus_glue import glue_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_HOLD = 40;
  localparam int TICK_DIV   = 32;
  localparam int CART_AW    = 10; // 1k image keeps downloads short
  localparam int N_RANDOM   = 3000;
  localparam int N_READS    = 400;

  logic         clk;
  logic         l_reset;
  machine_cfg_t cfg;
  cpu_bus_t     bus;
  sam_bus_t     sam;
  logic         spd_ena;
  logic         ddrb2;
  logic         portb2;
  src_data_t    src;
  logic [7:0]   vid_data;
  ioctl_t       ioctl;
  logic         use_dpad;
  logic [3:0]   dpad1;
  logic [3:0]   dpad2;
  joy_pos_t     analog1;
  joy_pos_t     analog2;
  logic         sys_ready;
  logic         cas_tick;
  dev_sel_t     sel;
  disk_strobe_t disk;
  logic [7:0]   cpu_din;
  logic [15:0]  video_addr;
  logic [7:0]   vdg_byte;
  logic         cart_loaded;
  joy_pos_t     joy_pos1;
  joy_pos_t     joy_pos2;

  integer seed;
  logic   hold_reset;   // l_reset level for the next drive
  logic   cart_bias;    // steer cycles into the romc slot
  int     cart_len;     // bytes of the current image
  ioctl_t next_ioctl;   // download port value for the next drive

  // model state
  int          m_edges;    // edges since release
  int          m_tick;
  logic        m_ready;
  logic        m_tick_out;
  logic [7:0]  m_mem [2**CART_AW];
  logic        m_dl_d;
  logic        m_loaded;
  logic [7:0]  m_cart_dout;
  logic        m_ras_r;
  logic        m_cas_r;
  logic        m_q_r;
  logic [7:0]  m_cap [8];  // ram rom8 rom8_alt roma roma_alt romc pia0 pia1
  logic [15:0] m_vaddr;
  logic [7:0]  m_vdg;
  joy_pos_t    m_joy1;
  joy_pos_t    m_joy2;

  dragon_bus_glue #(
    .RESET_HOLD (RESET_HOLD),
    .TICK_DIV   (TICK_DIV),
    .CART_AW    (CART_AW)
  ) dut_i (
    .clk         (clk),
    .l_reset     (l_reset),
    .cfg         (cfg),
    .bus         (bus),
    .sam         (sam),
    .spd_ena     (spd_ena),
    .ddrb2       (ddrb2),
    .portb2      (portb2),
    .src         (src),
    .vid_data    (vid_data),
    .ioctl       (ioctl),
    .use_dpad    (use_dpad),
    .dpad1       (dpad1),
    .dpad2       (dpad2),
    .analog1     (analog1),
    .analog2     (analog2),
    .sys_ready   (sys_ready),
    .cas_tick    (cas_tick),
    .sel         (sel),
    .disk        (disk),
    .cpu_din     (cpu_din),
    .video_addr  (video_addr),
    .vdg_byte    (vdg_byte),
    .cart_loaded (cart_loaded),
    .joy_pos1    (joy_pos1),
    .joy_pos2    (joy_pos2)
  );

  always #5 clk = ~clk; // 100 mhz

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // chip selects straight from the memory map rules
  function automatic dev_sel_t exp_sel();
    dev_sel_t s;
    logic     alt;
    logic     serial;
    alt        = cfg.dragon64 && ddrb2 && !portb2;
    serial     = cfg.dragon64 && bus.addr[2];
    s.ram      = (sam.dev_sel == 3'd0);
    s.rom8     = (sam.dev_sel == 3'd1) && !alt;
    s.rom8_alt = (sam.dev_sel == 3'd1) && alt;
    s.roma     = (sam.dev_sel == 3'd2) && !alt;
    s.roma_alt = (sam.dev_sel == 3'd2) && alt;
    s.romc     = (sam.dev_sel == 3'd3);
    s.pia0     = (sam.dev_sel == 3'd4) && !serial;
    s.acia     = (sam.dev_sel == 3'd4) && serial;
    s.pia1     = (sam.dev_sel == 3'd5);
    s.io       = (sam.dev_sel == 3'd6); // 7 leaves all low
    return s;
  endfunction

  function automatic disk_strobe_t exp_disk(input dev_sel_t s);
    disk_strobe_t d;
    logic         a3;
    logic         wd;
    logic         wr_cyc;
    a3           = cfg.dragon ? !bus.addr[3] : bus.addr[3];
    wd           = a3 && !(cfg.dragon && bus.addr[2]); // wd1793 window
    wr_cyc       = !bus.rw && sam.wr_ena;
    d.ff40_rd    = s.io && !a3 && (bus.addr[2:0] == 3'd0);
    d.ff40_wr    = d.ff40_rd && wr_cyc;
    d.wd_data_rd = s.io && wd;
    d.wd_rd      = s.io && wd && bus.rw && (bus.clk_e || bus.clk_q);
    d.wd_wr      = s.io && wd && wr_cyc;
    return d;
  endfunction

  function automatic logic [7:0] exp_din(input dev_sel_t s);
    if (s.ram)      return m_cap[0];
    if (s.rom8)     return m_cap[1];
    if (s.rom8_alt) return m_cap[2];
    if (s.roma)     return m_cap[3];
    if (s.roma_alt) return m_cap[4];
    if (s.romc)     return m_cap[5];
    if (s.acia)     return src.acia;  // live
    if (s.pia0)     return m_cap[6];
    if (s.pia1)     return m_cap[7];
    if (s.io)       return src.io;    // live
    return 8'hff;
  endfunction

  function automatic joy_pos_t dpad_to_pos(input logic [3:0] d);
    joy_pos_t p;
    p.x = d[1] ? joy_min : (d[0] ? joy_max : joy_center); // left over right
    p.y = d[3] ? joy_min : (d[2] ? joy_max : joy_center); // up over down
    return p;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s", what);
    $display("Result: FAILED");
    $fatal(1, "wait loop ran out");
  endtask

  // advance the model by one edge with the inputs held during the past cycle
  task automatic model_edge();
    dev_sel_t s;
    s = exp_sel();
    if (l_reset)
    begin
      m_edges    = 0;
      m_tick     = 0;
      m_ready    = 1'b0;
      m_tick_out = 1'b0;
      m_dl_d     = 1'b0;
      m_loaded   = 1'b0;
      m_ras_r    = 1'b0;
      m_cas_r    = 1'b0;
      m_q_r      = 1'b0;
      m_vaddr    = '0;
      m_vdg      = '0;
      m_joy1     = '{x: joy_center, y: joy_center};
      m_joy2     = '{x: joy_center, y: joy_center};
      for (int i = 0; i < 8; i++)
        m_cap[i] = '0;
    end
    else
    begin
      m_edges++;
      m_ready    = (m_edges >= RESET_HOLD);
      m_tick_out = (m_tick == 27);
      m_tick     = (m_tick + 1) % TICK_DIV;
      if (spd_ena) // read path sees the cartridge byte from before this edge
      begin
        if (sam.ras_n && !m_ras_r && bus.clk_e)
        begin
          m_cap[0] = vid_data;
          m_cap[1] = src.rom8;
          m_cap[2] = src.rom8_alt;
          m_cap[3] = src.roma;
          m_cap[4] = src.roma_alt;
          m_cap[5] = cfg.disk_cart_enabled ? src.romc_disk : m_cart_dout;
          m_cap[6] = src.pia0;
          m_cap[7] = src.pia1;
        end
        if (!sam.ras_n && m_ras_r)
          m_vaddr[7:0] = sam.ma;
        if (!sam.cas_n && m_cas_r)
          m_vaddr[15:8] = sam.ma;
        if (bus.clk_q && !m_q_r)
        begin
          m_vdg    = vid_data;
          m_cap[0] = vid_data;
        end
        m_ras_r = sam.ras_n;
        m_cas_r = sam.cas_n;
        m_q_r   = bus.clk_q;
      end
      if (s.romc && m_loaded)
        m_cart_dout = m_mem[bus.addr[CART_AW-1:0]]; // old contents
      if (ioctl.wr && ioctl.index == cart_index)
        m_mem[ioctl.addr[CART_AW-1:0]] = ioctl.data;
      if (m_dl_d && !ioctl.download && ioctl.index == cart_index)
        m_loaded = (ioctl.addr > cart_min_len);
      else if (cfg.disk_cart_enabled)
        m_loaded = 1'b0;
      m_dl_d = ioctl.download;
      m_joy1 = use_dpad ? dpad_to_pos(dpad1) : analog1;
      m_joy2 = use_dpad ? dpad_to_pos(dpad2) : analog2;
    end
  endtask

  task automatic check_registered();
    check_value("sys_ready", sys_ready, m_ready);
    check_value("cas_tick", cas_tick, m_tick_out);
    check_value("cart_loaded", cart_loaded, m_loaded);
    check_value("video_addr", video_addr, m_vaddr);
    check_value("vdg_byte", vdg_byte, m_vdg);
    check_value("joy_pos1", joy_pos1, m_joy1);
    check_value("joy_pos2", joy_pos2, m_joy2);
  endtask

  task automatic check_decoded();
    dev_sel_t s;
    s = exp_sel();
    check_value("sel", sel, s);
    check_value("disk", disk, exp_disk(s));
    check_value("cpu_din", cpu_din, exp_din(s));
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r        = rnd();
    l_reset  = hold_reset;
    cfg      = r[2:0];
    spd_ena  = r[3];
    ddrb2    = r[4];
    portb2   = r[5];
    use_dpad = r[6];
    dpad1    = r[11:8];
    dpad2    = r[15:12];
    vid_data = r[23:16];
    r        = rnd();
    bus      = r[18:0];
    r        = rnd();
    sam      = r[13:0];
    analog1  = r[31:16];
    r        = rnd();
    analog2  = r[15:0];
    src      = {rnd(), rnd(), r[23:16]};
    ioctl    = next_ioctl;
    if (cart_bias)
    begin
      cfg.disk_cart_enabled = ((rnd() & 32'd15) == 0); // rare disk rom swap
      if (rnd() & 32'd1)
        sam.dev_sel = sel_romc;
      bus.addr = 16'(rnd() % cart_len);
    end
    if (next_ioctl.download)
      cfg.disk_cart_enabled = 1'b0; // no flag clear mid transfer
  endtask

  task automatic run_cycle();
    @(posedge clk);
    #1;
    model_edge();
    check_registered();
    drive_inputs();
    #1;
    check_decoded();
  endtask

  // one image over the download port, then the falling download edge
  task automatic load_cart(input int len);
    for (int i = 0; i < len; i++)
    begin
      next_ioctl.addr     = 16'(i);
      next_ioctl.data     = 8'(rnd());
      next_ioctl.index    = cart_index;
      next_ioctl.download = 1'b1;
      next_ioctl.wr       = 1'b1;
      run_cycle();
    end
    next_ioctl.download = 1'b0; // addr holds the last byte
    next_ioctl.wr       = 1'b0;
    run_cycle();
    next_ioctl = '0;
  endtask

  initial
  begin
    int   n;
    int   len;
    logic exp_loaded;
    seed        = 32'he572_3be6;
    clk         = 1'b0;
    l_reset     = 1'b1;
    hold_reset  = 1'b1;
    cart_bias   = 1'b0;
    cart_len    = 1;
    next_ioctl  = '0;
    cfg         = '0;
    bus         = '0;
    sam         = '0;
    spd_ena     = 1'b0;
    ddrb2       = 1'b0;
    portb2      = 1'b0;
    src         = '0;
    vid_data    = '0;
    ioctl       = '0;
    use_dpad    = 1'b0;
    dpad1       = '0;
    dpad2       = '0;
    analog1     = '0;
    analog2     = '0;
    m_cart_dout = 'x; // cartridge port has no reset

    repeat (15)
      run_cycle();
    hold_reset = 1'b0;
    run_cycle(); // l_reset drops here

    n = 0;
    while (sys_ready !== 1'b1 && n < RESET_HOLD + 20)
    begin
      run_cycle();
      n++;
    end
    if (sys_ready !== 1'b1)
      stop_on_timeout("sys_ready never rose after reset");
    check_value("sys_ready delay", n, RESET_HOLD);

    repeat (N_RANDOM)
      run_cycle();

    // short, long, just at the limit, long again
    for (int k = 0; k < 4; k++)
    begin
      if (k == 2)
        len = int'(cart_min_len) + 1;
      else if (k % 2 == 0)
        len = 1 + int'(rnd() % 256);
      else
        len = int'(cart_min_len) + 2 + int'(rnd() % 766);
      exp_loaded = ((len - 1) > int'(cart_min_len));
      cart_len   = len;
      cart_bias  = 1'b1;
      load_cart(len);
      run_cycle(); // flag settles on the edge after download falls
      check_value("cart_loaded", cart_loaded, exp_loaded);
      repeat (N_READS)
        run_cycle();
    end
    cart_bias = 1'b0;

    repeat (N_RANDOM)
      run_cycle();

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: filelist.f
source/glue_pkg.sv
source/sys_control.sv
source/device_decode.sv
source/cart_store.sv
source/read_path.sv
source/joystick_pos.sv
source/dragon_bus_glue.sv
tb/tb_dragon_bus_glue.sv
